// ==== rtl/ps2_line_pkg.sv ====
package ps2_line_pkg;

	typedef logic [7:0] ps2_byte_t;	// one frame payload
	typedef logic [2:0] bit_idx_t;	// data bit position, lsb first

	// ------------------------------
	// host to device frame
	typedef enum logic [3:0]
	{
		tx_idle,
		tx_hold_clock,	// clock pulled low, request to send
		tx_start_bit,	// data low, clock released
		tx_data_bits,
		tx_parity_bit,
		tx_stop_bit,	// data released
		tx_wait_ack,
		tx_done,
		tx_fail
	} tx_state_t;

	// device to host frame
	typedef enum logic [1:0]
	{
		rx_idle,
		rx_data_bits,
		rx_parity_bit,
		rx_stop_bit
	} rx_state_t;

	// parity bit so data plus parity holds an odd count of ones
	function automatic logic odd_parity(input ps2_byte_t data);
		return ~^data;
	endfunction

endpackage

// ==== rtl/ps2_host_pkg.sv ====
package ps2_host_pkg;

	typedef logic [3:0] credit_t;	// receive credits held by the host
	typedef logic [19:0] cycles_t;	// hold and timeout counts, up to ~20 ms at 50 MHz

	// why the last command failed
	typedef enum logic [1:0]
	{
		none,
		no_ack,	// frame sent, device never acknowledged
		line_timeout	// device stopped clocking mid frame
	} err_cause_t;

endpackage

// ==== rtl/ps2_line_if.sv ====
interface ps2_line_if;

	logic clk_level;	// synchronised pin levels
	logic data_level;
	logic clk_fall;	// one cycle edge events
	logic clk_rise;

	logic tx_clk_low;	// drive low requests
	logic tx_data_low;
	logic inhibit_clk_low;	// receive back-pressure from the top

	modport sync
	(
		output clk_level, data_level, clk_fall, clk_rise,
		input tx_clk_low, tx_data_low, inhibit_clk_low
	);

	modport tx
	(
		input clk_level, data_level, clk_fall, clk_rise,
		output tx_clk_low, tx_data_low
	);

	modport rx
	(
		input clk_level, data_level, clk_fall, clk_rise
	);

endinterface

// ==== rtl/ps2_line_sync.sv ====
module ps2_line_sync
(
	input logic clk,
	input logic reset,
	input logic clk_pin,
	input logic data_pin,
	output logic clk_low,	// high pulls the pin low
	output logic data_low,
	ps2_line_if.sync line
);

	logic [2:0] clk_sync;	// two sync flops then the previous level
	logic [2:0] data_sync;
	logic fall_q;
	logic rise_q;

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			clk_sync <= '1;	// released lines idle high
			data_sync <= '1;
			fall_q <= 1'b0;
			rise_q <= 1'b0;
			clk_low <= 1'b0;
			data_low <= 1'b0;
		end
		else
		begin
			clk_sync <= {clk_sync[1:0], clk_pin};
			data_sync <= {data_sync[1:0], data_pin};
			fall_q <= clk_sync[2] && !clk_sync[1];	// event lands 3 cycles after the pin
			rise_q <= !clk_sync[2] && clk_sync[1];
			// registered drive merge onto the pins
			clk_low <= line.tx_clk_low || line.inhibit_clk_low;
			data_low <= line.tx_data_low;
		end
	end

	assign line.clk_level = clk_sync[2];	// aligned with the edge events
	assign line.data_level = data_sync[2];
	assign line.clk_fall = fall_q;
	assign line.clk_rise = rise_q;

	// inhibit never overlaps a transmitter drive
	a_no_drive_clash: assert property (@(posedge clk) disable iff (!reset)
		!(line.inhibit_clk_low && (line.tx_clk_low || line.tx_data_low)));

endmodule

// ==== rtl/ps2_cmd_tx.sv ====
module ps2_cmd_tx
#(
	parameter ps2_host_pkg::cycles_t hold_cycles = 5000,
	parameter ps2_host_pkg::cycles_t timeout_cycles = 750000
)
(
	input logic clk,
	input logic reset,
	input ps2_line_pkg::ps2_byte_t cmd_byte,
	input logic cmd_valid,
	output logic busy,
	output logic done,
	output logic fail,
	output ps2_host_pkg::err_cause_t cause,
	ps2_line_if.tx line
);
	import ps2_line_pkg::*;
	import ps2_host_pkg::*;

	tx_state_t state;
	ps2_byte_t cmd_q;	// latched command
	logic parity_q;
	bit_idx_t idx;
	cycles_t count;	// hold time first then cycles since last progress
	logic in_frame;
	logic ack;
	logic progress;
	logic hold_end;
	logic data_low;

	assign in_frame = state inside {tx_start_bit, tx_data_bits, tx_parity_bit,
		tx_stop_bit, tx_wait_ack};
	assign ack = line.clk_rise && !line.data_level;	// device holds data low as the clock rises
	assign progress = in_frame && (line.clk_fall || ack);
	assign hold_end = (state == tx_hold_clock) && (count == hold_cycles - 1'b1);

	// payload and its parity latched once
	always_ff @(posedge clk)
	begin
		if (state == tx_idle && cmd_valid)
		begin
			cmd_q <= cmd_byte;
			parity_q <= odd_parity(cmd_byte);
		end
	end

	// ------------------------------
	// frame FSM
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			state <= tx_idle;
			idx <= '0;
			count <= '0;
			cause <= none;
		end
		else
		begin
			if (state == tx_idle || hold_end || progress)
				count <= '0;	// restarts at clock release
			else
				count <= count + 1'b1;
			case (state)
			tx_idle:
				if (cmd_valid)
				begin
					state <= tx_hold_clock;
					cause <= none;
				end
			tx_hold_clock:
				if (hold_end)
					state <= tx_start_bit;
			tx_start_bit:
				if (line.clk_fall)
				begin
					state <= tx_data_bits;
					idx <= '0;
				end
			tx_data_bits:
				if (line.clk_fall)
				begin
					idx <= idx + 1'b1;
					if (idx == 3'd7)
						state <= tx_parity_bit;
				end
			tx_parity_bit:
				if (line.clk_fall)
					state <= tx_stop_bit;
			tx_stop_bit:
				if (line.clk_fall)
					state <= tx_wait_ack;	// device drives ack next
			tx_wait_ack:
				if (ack)
					state <= tx_done;
			default:
				state <= tx_idle;	// done and fail last one cycle
			endcase
			// stalled frame gives up and frees both lines
			if (in_frame && !progress && count == timeout_cycles - 1'b1)
			begin
				state <= tx_fail;
				cause <= (state == tx_wait_ack) ? no_ack : line_timeout;
			end
		end
	end

	always_comb
	begin
		data_low = 1'b0;	// stop bit and ack leave data released
		case (state)
		tx_start_bit: data_low = 1'b1;
		tx_data_bits: data_low = !cmd_q[idx];
		tx_parity_bit: data_low = !parity_q;
		default: data_low = 1'b0;
		endcase
	end

	assign line.tx_clk_low = (state == tx_hold_clock);
	assign line.tx_data_low = data_low;
	assign busy = (state != tx_idle);
	assign done = (state == tx_done);
	assign fail = (state == tx_fail);

	// ------------------------------
	// checks
	a_no_cmd_while_busy: assert property (@(posedge clk) disable iff (!reset)
		cmd_valid |-> !busy);
	// own hold comes back low through the pin and the synchroniser
	a_hold_reaches_pin: assert property (@(posedge clk) disable iff (!reset)
		(state == tx_hold_clock && count > 4) |-> !line.clk_level);

endmodule

// ==== rtl/ps2_byte_rx.sv ====
module ps2_byte_rx
#(
	parameter ps2_host_pkg::cycles_t timeout_cycles = 750000
)
(
	input logic clk,
	input logic reset,
	input logic enable,	// low while the transmitter owns the lines
	output ps2_line_pkg::ps2_byte_t byte_out,
	output logic valid,
	output logic error,
	output logic receiving,
	ps2_line_if.rx line
);
	import ps2_line_pkg::*;
	import ps2_host_pkg::*;

	rx_state_t state;
	ps2_byte_t shift_q;
	logic parity_q;
	bit_idx_t idx;
	cycles_t count;	// time since last falling edge
	logic bad_frame;

	// parity mismatch or stop bit read as 0
	assign bad_frame = (parity_q != odd_parity(shift_q)) || !line.data_level;

	always_ff @(posedge clk)
	begin
		if (line.clk_fall && state == rx_data_bits)
			shift_q <= {line.data_level, shift_q[7:1]};	// lsb arrives first
		if (line.clk_fall && state == rx_parity_bit)
			parity_q <= line.data_level;
	end

	// ------------------------------
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			state <= rx_idle;
			idx <= '0;
			count <= '0;
			valid <= 1'b0;
			error <= 1'b0;
		end
		else
		begin
			valid <= 1'b0;
			error <= 1'b0;
			if (state == rx_idle || line.clk_fall || !line.clk_level)
				count <= '0;	// counts only while the clock idles high
			else
				count <= count + 1'b1;
			if (!enable)
				state <= rx_idle;
			else if (state != rx_idle && count == timeout_cycles - 1'b1)
				state <= rx_idle;	// stalled frame dropped without a pulse
			else if (line.clk_fall)
			begin
				case (state)
				rx_idle:
					if (!line.data_level)	// start bit
					begin
						state <= rx_data_bits;
						idx <= '0;
					end
				rx_data_bits:
				begin
					idx <= idx + 1'b1;
					if (idx == 3'd7)
						state <= rx_parity_bit;
				end
				rx_parity_bit:
					state <= rx_stop_bit;
				rx_stop_bit:
				begin
					state <= rx_idle;
					valid <= !bad_frame;
					error <= bad_frame;
				end
				endcase
			end
		end
	end

	assign byte_out = shift_q;
	assign receiving = (state != rx_idle);

	// stop bit taken inside a full clock low phase
	a_stop_in_low_phase: assert property (@(posedge clk) disable iff (!reset)
		(valid || error) |-> !line.clk_level);

endmodule

// ==== rtl/ps2_host.sv ====
module ps2_host
#(
	parameter ps2_host_pkg::cycles_t hold_cycles = 5000,	// 100 us at 50 MHz
	parameter ps2_host_pkg::cycles_t timeout_cycles = 750000,	// 15 ms
	parameter ps2_host_pkg::credit_t rx_credit_max = 4
)
(
	input logic clk,
	input logic reset,
	input logic ps2_clk_in,
	input logic ps2_data_in,
	output logic ps2_clk_low,
	output logic ps2_data_low,
	input ps2_line_pkg::ps2_byte_t cmd_byte,
	input logic cmd_valid,
	output logic cmd_credit,
	output logic cmd_done,
	output logic cmd_error,
	output ps2_host_pkg::err_cause_t cmd_cause,
	output ps2_line_pkg::ps2_byte_t rx_byte,
	output logic rx_valid,
	output logic rx_error,
	input logic rx_credit_return
);
	import ps2_host_pkg::*;

	ps2_line_if line ();

	logic tx_busy;
	logic rx_receiving;
	logic [1:0] boot_q;	// one-shot first command credit
	credit_t rx_credits;
	logic rx_spend;
	logic rx_gain;

	// ------------------------------
	// credits
	assign rx_spend = (rx_valid || rx_error) && (rx_credits != '0);
	assign rx_gain = rx_credit_return && (rx_credits != rx_credit_max || rx_spend);

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			boot_q <= 2'b00;
			rx_credits <= rx_credit_max;
		end
		else
		begin
			boot_q <= {boot_q[0], 1'b1};
			if (rx_spend && !rx_gain)
				rx_credits <= rx_credits - 1'b1;
			else if (rx_gain && !rx_spend)
				rx_credits <= rx_credits + 1'b1;	// capped at max by rx_gain
		end
	end

	// next command allowed once the last one has ended
	assign cmd_credit = (boot_q == 2'b01) || cmd_done || cmd_error;
	// hold the device off, never cutting into a byte on the wire
	assign line.inhibit_clk_low = (rx_credits == '0) && !tx_busy && !rx_receiving;

	// ------------------------------
	ps2_line_sync u_sync
	(
		.clk(clk),
		.reset(reset),
		.clk_pin(ps2_clk_in),
		.data_pin(ps2_data_in),
		.clk_low(ps2_clk_low),
		.data_low(ps2_data_low),
		.line(line.sync)
	);

	ps2_cmd_tx #(.hold_cycles(hold_cycles), .timeout_cycles(timeout_cycles)) u_tx
	(
		.clk(clk),
		.reset(reset),
		.cmd_byte(cmd_byte),
		.cmd_valid(cmd_valid),
		.busy(tx_busy),
		.done(cmd_done),
		.fail(cmd_error),
		.cause(cmd_cause),
		.line(line.tx)
	);

	ps2_byte_rx #(.timeout_cycles(timeout_cycles)) u_rx
	(
		.clk(clk),
		.reset(reset),
		.enable(!tx_busy),	// receiver idle while a command is out
		.byte_out(rx_byte),
		.valid(rx_valid),
		.error(rx_error),
		.receiving(rx_receiving),
		.line(line.rx)
	);

endmodule

// ==== test/ps2_device_model.sv ====
module ps2_device_model
(
	input logic clk,
	input logic bus_clk,	// wired-and line levels
	input logic bus_data,
	output logic clk_low,	// device pulls the line low
	output logic data_low,
	input logic send_req,	// held high until the byte is taken
	input ps2_line_pkg::ps2_byte_t send_byte,
	input logic send_parity,
	input logic suppress_ack,
	output ps2_line_pkg::ps2_byte_t cmd_seen,	// last host command
	output logic parity_seen,
	output logic stop_seen
);
	import ps2_line_pkg::*;

	localparam int half_period = 10;	// system cycles per clock phase

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// ------------------------------
	// host to device, device clocks and samples
	task automatic take_command;
		wait_cycles(half_period);
		for (int i = 0; i < 11; i++)
		begin
			clk_low = 1'b1;
			if (i == 10 && !suppress_ack)
				data_low = 1'b1;	// ack rides the 11th clock
			wait_cycles(half_period);
			// host set this bit on the falling edge, sample before the rise
			if (i < 8)
				cmd_seen = {bus_data, cmd_seen[7:1]};	// lsb first
			else if (i == 8)
				parity_seen = bus_data;
			else if (i == 9)
				stop_seen = bus_data;
			clk_low = 1'b0;
			wait_cycles(half_period);
		end
		data_low = 1'b0;
	endtask

	// device to host frame
	task automatic give_byte;
		logic [10:0] frame;
		frame = {1'b1, send_parity, send_byte, 1'b0};	// stop, parity, data, start
		repeat (11)
		begin
			data_low = !frame[0];
			frame = frame >> 1;
			wait_cycles(half_period / 2);	// data settles while clock high
			clk_low = 1'b1;
			wait_cycles(half_period);
			clk_low = 1'b0;
			wait_cycles(half_period / 2);
		end
		data_low = 1'b0;
	endtask

	// ------------------------------
	initial
	begin
		clk_low = 1'b0;
		data_low = 1'b0;
		cmd_seen = '0;
		parity_seen = 1'b0;
		stop_seen = 1'b0;
		forever
		begin
			@(negedge clk);
			if (bus_clk && !bus_data)	// request to send, clock released
				take_command();
			else if (send_req && bus_clk && bus_data)	// never while inhibited
			begin
				give_byte();
				while (send_req)
					@(negedge clk);
			end
		end
	end

endmodule

// ==== test/ps2_host_tb.sv ====
module ps2_host_tb;
	import ps2_line_pkg::*;
	import ps2_host_pkg::*;

	localparam cycles_t hold_c = 20'd40;
	localparam cycles_t timeout_c = 20'd2000;
	localparam credit_t credit_max = 4'd2;
	// longest wait for one end pulse, a command with no ack
	localparam int frame_limit = int'(hold_c) + int'(timeout_c) + 12 * 20 * 2;

	logic clk;
	logic reset;
	logic bus_clk;
	logic bus_data;
	logic ps2_clk_low;
	logic ps2_data_low;
	logic dev_clk_low;
	logic dev_data_low;
	ps2_byte_t cmd_byte;
	logic cmd_valid;
	logic cmd_credit;
	logic cmd_done;
	logic cmd_error;
	err_cause_t cmd_cause;
	ps2_byte_t rx_byte;
	logic rx_valid;
	logic rx_error;
	logic rx_credit_return;
	logic send_req;
	ps2_byte_t send_byte;
	logic send_parity;
	logic suppress_ack;
	ps2_byte_t cmd_seen;
	logic parity_seen;
	logic stop_seen;

	logic [15:0] patterns [0:15];
	logic [3:0] slot;
	int pattern_count;
	logic loaded;
	integer seed;
	int gap;
	int credits;	// receive credits the host should hold
	int commands_sent;
	int credit_pulses;
	logic boot_seen;
	logic rx_expected;

	assign bus_clk = !(ps2_clk_low || dev_clk_low);	// open drain, either side pulls low
	assign bus_data = !(ps2_data_low || dev_data_low);

	ps2_host #(.hold_cycles(hold_c), .timeout_cycles(timeout_c), .rx_credit_max(credit_max)) DUT
	(
		.clk(clk),
		.reset(reset),
		.ps2_clk_in(bus_clk),
		.ps2_data_in(bus_data),
		.ps2_clk_low(ps2_clk_low),
		.ps2_data_low(ps2_data_low),
		.cmd_byte(cmd_byte),
		.cmd_valid(cmd_valid),
		.cmd_credit(cmd_credit),
		.cmd_done(cmd_done),
		.cmd_error(cmd_error),
		.cmd_cause(cmd_cause),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.rx_error(rx_error),
		.rx_credit_return(rx_credit_return)
	);

	ps2_device_model device
	(
		.clk(clk),
		.bus_clk(bus_clk),
		.bus_data(bus_data),
		.clk_low(dev_clk_low),
		.data_low(dev_data_low),
		.send_req(send_req),
		.send_byte(send_byte),
		.send_parity(send_parity),
		.suppress_ack(suppress_ack),
		.cmd_seen(cmd_seen),
		.parity_seen(parity_seen),
		.stop_seen(stop_seen)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ------------------------------
	// failure reporting and compares
	task automatic abort_run;
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		abort_run();
	endtask

	task automatic check_byte(input string name, input ps2_byte_t got, input ps2_byte_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_cause(input string name, input err_cause_t got, input err_cause_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	// odd parity, counted bit by bit
	function automatic logic parity_for(input ps2_byte_t value);
		ps2_byte_t v;
		int ones;
		v = value;
		ones = 0;
		repeat (8)
		begin
			if (v[0])
				ones++;
			v = v >> 1;
		end
		return (ones % 2) == 0;
	endfunction

	task automatic wait_for_end(input logic rx_side, input string what);
		int cycles;
		cycles = 0;
		while (rx_side ? !(rx_valid || rx_error) : !(cmd_done || cmd_error))
		begin
			@(negedge clk);
			cycles++;
			if (cycles > frame_limit)
				report_failure($sformatf("no %s within %0d cycles", what, frame_limit));
		end
	endtask

	// ------------------------------
	// operations
	task automatic issue_command(input ps2_byte_t value, input logic no_ack_flag);
		if (credit_pulses <= commands_sent)
			report_failure("command due but the host holds no command credit");
		suppress_ack = no_ack_flag;
		cmd_byte = value;
		cmd_valid = 1'b1;
		commands_sent++;
		@(negedge clk);
		cmd_valid = 1'b0;
		wait_for_end(1'b0, "cmd_done or cmd_error");
		check_flag("cmd_credit", cmd_credit, 1'b1);	// next credit with the end pulse
		if (no_ack_flag)
		begin
			check_flag("cmd_error", cmd_error, 1'b1);
			check_cause("cmd_cause", cmd_cause, no_ack);
			repeat (2) @(negedge clk);	// drives are registered
			check_flag("ps2_clk_low", ps2_clk_low, 1'b0);
			check_flag("ps2_data_low", ps2_data_low, 1'b0);
		end
		else
		begin
			check_flag("cmd_done", cmd_done, 1'b1);
			check_flag("cmd_error", cmd_error, 1'b0);
			check_byte("cmd_seen", cmd_seen, value);
			check_flag("parity_seen", parity_seen, parity_for(value));
			check_flag("stop_seen", stop_seen, 1'b1);
		end
	endtask

	task automatic return_credit;
		rx_credit_return = 1'b1;
		@(negedge clk);
		rx_credit_return = 1'b0;
		if (credits < int'(credit_max))
			credits++;
	endtask

	// no credits, the clock must stay inhibited and nothing may arrive
	task automatic expect_hold_off;
		repeat (300)
		begin
			@(negedge clk);
			check_flag("ps2_clk_low", ps2_clk_low, 1'b1);
			if (rx_valid || rx_error)
				report_failure("device byte got through while the host had no receive credit");
		end
	endtask

	task automatic send_device_byte(input ps2_byte_t value, input logic bad_parity);
		send_byte = value;
		send_parity = parity_for(value) ^ bad_parity;
		rx_expected = 1'b1;
		send_req = 1'b1;
		if (credits == 0)
		begin
			expect_hold_off();
			return_credit();
		end
		wait_for_end(1'b1, "rx_valid or rx_error");
		check_flag("rx_valid", rx_valid, !bad_parity);
		check_flag("rx_error", rx_error, bad_parity);
		if (!bad_parity)
			check_byte("rx_byte", rx_byte, value);
		credits--;
		@(negedge clk);
		send_req = 1'b0;
		rx_expected = 1'b0;
	endtask

	task automatic dispatch_pattern(input logic [15:0] word);
		case (word[15:12])
		4'h0: issue_command(word[7:0], word[8]);
		4'h1: send_device_byte(word[7:0], word[9]);
		4'h2: return_credit();
		default: report_failure("unknown operation in the pattern file");
		endcase
	endtask

	// ------------------------------
	// credit and receive monitor
	always @(negedge clk)
	begin
		if (reset && (rx_valid || rx_error) && !rx_expected)
			report_failure("receive pulse with no device byte on the way");
		if (reset && cmd_credit)
		begin
			if (credit_pulses > commands_sent)
				report_failure("cmd_credit pulsed again before the last credit was used");
			if (!(cmd_done || cmd_error))
			begin
				if (boot_seen)
					report_failure("cmd_credit pulsed without cmd_done or cmd_error");
				boot_seen = 1'b1;	// first credit after reset
			end
			credit_pulses++;
		end
	end

	initial
	begin
		int limit_cycles;
		wait (loaded);
		limit_cycles = pattern_count * (int'(timeout_c) + 12 * 20 + int'(hold_c)) * 2;
		#(limit_cycles * 40);
		report_failure($sformatf("timeout, run still busy after %0d cycles", limit_cycles));
	end

	initial
	begin
		int cycles;
		reset = 1'b0;
		cmd_byte = '0;
		cmd_valid = 1'b0;
		rx_credit_return = 1'b0;
		send_req = 1'b0;
		send_byte = '0;
		send_parity = 1'b0;
		suppress_ack = 1'b0;
		seed = 32'hfb55_9fde;
		credits = int'(credit_max);
		commands_sent = 0;
		credit_pulses = 0;
		boot_seen = 1'b0;
		rx_expected = 1'b0;
		loaded = 1'b0;
		slot = '0;
		repeat (16)
		begin
			patterns[slot] = {4'hf, 8'h00, slot};	// op f ends the list
			slot = slot + 1'b1;
		end
		$readmemh("test/ps2_patterns.hex", patterns);
		pattern_count = 0;
		slot = '0;
		while (patterns[slot][15:12] != 4'hf && pattern_count < 15)
		begin
			pattern_count++;
			slot = slot + 1'b1;
		end
		loaded = 1'b1;
		repeat (3) @(negedge clk);
		reset = 1'b1;
		cycles = 0;
		while (credit_pulses == 0)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > 8)
				report_failure("no cmd_credit after reset");
		end
		slot = '0;
		repeat (pattern_count)
		begin
			gap = 4 + ($random(seed) & 15);
			repeat (gap) @(negedge clk);
			dispatch_pattern(patterns[slot]);
			slot = slot + 1'b1;
		end
		repeat (10) @(negedge clk);
		$display("Test passed");
		$finish;
	end

endmodule

// ==== ps2_host.f ====
rtl/ps2_line_pkg.sv
rtl/ps2_host_pkg.sv
rtl/ps2_line_if.sv
rtl/ps2_line_sync.sv
rtl/ps2_cmd_tx.sv
rtl/ps2_byte_rx.sv
rtl/ps2_host.sv
test/ps2_device_model.sv
test/ps2_host_tb.sv

// ==== Makefile ====
TOP = ps2_host_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f ps2_host.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== test/ps2_patterns.hex ====
// op[15:12] 0 host command, 1 device byte, 2 return one receive credit
// flags[11:8] bit 0 suppress ack, bit 1 corrupt parity; data byte in [7:0]
00f4
01ff
10aa
2000
1255
2000
103c
10c3
1081 // no credit left here, the byte waits for a return
2000
2000
00ed
1000
